// File: verilog/msix_defs.svh
`ifndef MSIX_DEFS_SVH
`define MSIX_DEFS_SVH

// --------------------------------------------------
// Table geometry
// --------------------------------------------------
`define MSIX_NUM_VECTORS 4
`define MSIX_FIFO_DEPTH 8

// --------------------------------------------------
// Configuration word selectors
// --------------------------------------------------
`define MSIX_WORD_ADDR_LO 2'd0
`define MSIX_WORD_ADDR_HI 2'd1
`define MSIX_WORD_DATA 2'd2
// Bit 0 of this word is the vector mask
`define MSIX_WORD_CTRL 2'd3

`endif

// File: verilog/msix_pkg.sv
package msix_pkg;

   // --------------------------------------------------
   // Message payload
   // --------------------------------------------------
   typedef logic [63:0] msix_addr_t;
   typedef logic [31:0] msix_data_t;

   // Vector index into the table
   typedef logic [1:0] msix_vec_t;

   // Configuration write data
   typedef logic [31:0] cfg_word_t;

   // --------------------------------------------------
   // Output bridge FSM
   // --------------------------------------------------
   typedef enum logic {
      OUT_IDLE,
      OUT_SEND
   } msix_out_state_e;

endpackage

// File: verilog/msix_vec_if.sv
`timescale 1ns/1ps

interface msix_vec_if;
   import msix_pkg::*;

   // Vector is pending and not masked
   logic offer;

   // Table entry of the vector
   msix_addr_t addr;
   msix_data_t data;

   // One-cycle grant from the arbiter
   logic ack;

   modport vec (
      output offer,
      output addr,
      output data,
      input  ack
   );

   modport arb (
      input  offer,
      input  addr,
      input  data,
      output ack
   );

endinterface

// File: verilog/msix_msg_if.sv
`timescale 1ns/1ps

interface msix_msg_if;
   import msix_pkg::*;

   // Write strobe into the message FIFO
   logic push;

   // Message carried by the push
   msix_addr_t addr;
   msix_data_t data;

   // FIFO has no free entry
   logic full;

   modport src (
      output push,
      output addr,
      output data,
      input  full
   );

   modport dst (
      input  push,
      input  addr,
      input  data,
      output full
   );

endinterface

// File: verilog/msix_table.sv
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_table (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      i_cfg_wr,
   input  msix_pkg::msix_vec_t       i_cfg_vec,
   input  logic [1:0]                i_cfg_word,
   input  msix_pkg::cfg_word_t       i_cfg_wdata,
   output msix_pkg::msix_addr_t      o_addr [`MSIX_NUM_VECTORS],
   output msix_pkg::msix_data_t      o_data [`MSIX_NUM_VECTORS],
   output logic [`MSIX_NUM_VECTORS-1:0] o_mask
);
   import msix_pkg::*;

   msix_addr_t addr_q [`MSIX_NUM_VECTORS];
   msix_data_t data_q [`MSIX_NUM_VECTORS];
   logic [`MSIX_NUM_VECTORS-1:0] mask_q;

   // --------------------------------------------------
   // Configuration write decode
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Every vector comes up masked with an empty entry
         for (int v = 0; v < `MSIX_NUM_VECTORS; v++) begin
            addr_q[v] <= '0;
            data_q[v] <= '0;
         end
         mask_q <= '1;
      end else if (i_cfg_wr) begin
         case (i_cfg_word)
            `MSIX_WORD_ADDR_LO: begin
               addr_q[i_cfg_vec][31:0] <= i_cfg_wdata;
            end
            `MSIX_WORD_ADDR_HI: begin
               addr_q[i_cfg_vec][63:32] <= i_cfg_wdata;
            end
            `MSIX_WORD_DATA: begin
               data_q[i_cfg_vec] <= i_cfg_wdata;
            end
            `MSIX_WORD_CTRL: begin
               mask_q[i_cfg_vec] <= i_cfg_wdata[0];
            end
         endcase
      end
   end

   // Entries out to the vector modules
   assign o_mask = mask_q;

   generate
      for (genvar g = 0; g < `MSIX_NUM_VECTORS; g++) begin : g_out
         assign o_addr[g] = addr_q[g];
         assign o_data[g] = data_q[g];
      end
   endgenerate

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   // Writes must target a known vector index
   a_cfg_vec_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      i_cfg_wr |-> !$isunknown(i_cfg_vec)
   );

endmodule

// File: verilog/msix_vector.sv
`timescale 1ns/1ps

module msix_vector (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 i_irq,
   input  logic                 i_mask,
   input  msix_pkg::msix_addr_t i_addr,
   input  msix_pkg::msix_data_t i_data,
   output logic                 o_pending,
   msix_vec_if.vec              port_vec
);

   logic pending_q;

   // --------------------------------------------------
   // Pending bit
   // --------------------------------------------------
   // A pulse that lands while already pending merges into the same message.
   // A pulse in the ack cycle wins so that it is not dropped.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending_q <= 1'b0;
      end else if (i_irq) begin
         pending_q <= 1'b1;
      end else if (port_vec.ack) begin
         pending_q <= 1'b0;
      end
   end

   assign o_pending = pending_q;

   // Masked vectors hold pending without offering
   assign port_vec.offer = pending_q & ~i_mask;

   // Message content comes straight from the table entry
   assign port_vec.addr = i_addr;
   assign port_vec.data = i_data;

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   // Arbiter may only grant an offering vector
   a_ack_needs_offer : assert property (
      @(posedge clk) disable iff (!rst_n)
      port_vec.ack |-> port_vec.offer
   );

endmodule

// File: verilog/msix_arbiter.sv
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_arbiter (
   input  logic     clk,
   input  logic     rst_n,
   msix_vec_if.arb  port_vecs [`MSIX_NUM_VECTORS],
   msix_msg_if.src  port_msg
);
   import msix_pkg::*;

   logic [`MSIX_NUM_VECTORS-1:0] offer;
   logic [`MSIX_NUM_VECTORS-1:0] grant;
   msix_addr_t addr_arr [`MSIX_NUM_VECTORS];
   msix_data_t data_arr [`MSIX_NUM_VECTORS];
   msix_vec_t  ptr_q;
   msix_vec_t  sel;
   logic       push;

   // Gather the vector interfaces into indexable arrays
   generate
      for (genvar g = 0; g < `MSIX_NUM_VECTORS; g++) begin : g_port
         assign offer[g]           = port_vecs[g].offer;
         assign addr_arr[g]        = port_vecs[g].addr;
         assign data_arr[g]        = port_vecs[g].data;
         assign port_vecs[g].ack   = grant[g];
      end
   endgenerate

   // --------------------------------------------------
   // Round-robin pick
   // --------------------------------------------------
   // First offering vector at or after the pointer
   always_comb begin : pick
      msix_vec_t idx;
      logic      found;
      found = 1'b0;
      sel   = ptr_q;
      for (int i = 0; i < `MSIX_NUM_VECTORS; i++) begin
         idx = msix_vec_t'((int'(ptr_q) + i) % `MSIX_NUM_VECTORS);
         if (!found && offer[idx]) begin
            sel   = idx;
            found = 1'b1;
         end
      end
   end

   // FIFO full holds everything back
   assign push = (|offer) & ~port_msg.full;

   always_comb begin
      grant = '0;
      if (push) begin
         grant[sel] = 1'b1;
      end
   end

   assign port_msg.push = push;
   assign port_msg.addr = addr_arr[sel];
   assign port_msg.data = data_arr[sel];

   // Skip past the winner for fairness
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ptr_q <= '0;
      end else if (push) begin
         ptr_q <= msix_vec_t'((int'(sel) + 1) % `MSIX_NUM_VECTORS);
      end
   end

endmodule

// File: verilog/msix_fifo.sv
`timescale 1ns/1ps

module msix_fifo #(
   parameter int WIDTH = 96,
   parameter int DEPTH = 8
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             i_wr,
   input  logic [WIDTH-1:0] i_wdata,
   output logic             o_full,
   input  logic             i_rd,
   output logic [WIDTH-1:0] o_rdata,
   output logic             o_empty
);

   // DEPTH is a power of two
   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];

   // One extra bit tells full from empty
   logic [AW:0] wr_ptr_q;
   logic [AW:0] rd_ptr_q;

   assign o_empty = (wr_ptr_q == rd_ptr_q);
   assign o_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                    (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

   // --------------------------------------------------
   // Storage and registered read port
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_wr && !o_full) begin
         mem[wr_ptr_q[AW-1:0]] <= i_wdata;
      end
      if (i_rd && !o_empty) begin
         o_rdata <= mem[rd_ptr_q[AW-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (i_wr && !o_full) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (i_rd && !o_empty) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   a_no_read_empty : assert property (
      @(posedge clk) disable iff (!rst_n)
      i_rd |-> !o_empty
   );

   // A write into a full buffer would be lost
   a_no_write_full : assert property (
      @(posedge clk) disable iff (!rst_n)
      i_wr |-> !o_full
   );

endmodule

// File: verilog/msix_bridge.sv
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_bridge (
   input  logic                 clk,
   input  logic                 rst_n,
   msix_msg_if.dst              port_msg,
   input  logic                 i_msix_ready,
   output logic                 o_msix_valid,
   output msix_pkg::msix_addr_t o_msix_addr,
   output msix_pkg::msix_data_t o_msix_data
);
   import msix_pkg::*;

   localparam int MSG_W = $bits(msix_addr_t) + $bits(msix_data_t);

   msix_out_state_e state_q;
   msix_out_state_e state_d;
   logic             fifo_empty;
   logic             fifo_rd;
   logic [MSG_W-1:0] fifo_rdata;
   logic             empty_q;
   logic             rd_q;

   msix_fifo #(
      .WIDTH (MSG_W),
      .DEPTH (`MSIX_FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .i_wr    (port_msg.push),
      .i_wdata ({port_msg.addr, port_msg.data}),
      .o_full  (port_msg.full),
      .i_rd    (fifo_rd),
      .o_rdata (fifo_rdata),
      .o_empty (fifo_empty)
   );

   // --------------------------------------------------
   // Pop control
   // --------------------------------------------------
   // Empty is looked at one cycle late, and a pop blocks the next cycle
   assign fifo_rd = ~empty_q & ~rd_q & (state_q == OUT_IDLE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         empty_q <= 1'b1;
         rd_q    <= 1'b0;
      end else begin
         empty_q <= fifo_empty;
         rd_q    <= fifo_rd;
      end
   end

   // --------------------------------------------------
   // Output FSM
   // --------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         OUT_IDLE: if (rd_q) state_d = OUT_SEND;
         OUT_SEND: if (i_msix_ready) state_d = OUT_IDLE;
         default:  state_d = OUT_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= OUT_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Read data lands the cycle after the pop
   always_ff @(posedge clk) begin
      if (rd_q) begin
         {o_msix_addr, o_msix_data} <= fifo_rdata;
      end
   end

   assign o_msix_valid = (state_q == OUT_SEND);

   // Message must not change while the host stalls it
   a_hold_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (o_msix_valid && !i_msix_ready) |=>
         (o_msix_valid && $stable(o_msix_addr) && $stable(o_msix_data))
   );

endmodule

// File: verilog/msix_top.sv
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          i_cfg_wr,
   input  msix_pkg::msix_vec_t           i_cfg_vec,
   input  logic [1:0]                    i_cfg_word,
   input  msix_pkg::cfg_word_t           i_cfg_wdata,
   input  logic [`MSIX_NUM_VECTORS-1:0]  i_irq,
   input  logic                          i_msix_ready,
   output logic                          o_msix_valid,
   output msix_pkg::msix_addr_t          o_msix_addr,
   output msix_pkg::msix_data_t          o_msix_data,
   output logic [`MSIX_NUM_VECTORS-1:0]  o_pba
);
   import msix_pkg::*;

   msix_addr_t tbl_addr [`MSIX_NUM_VECTORS];
   msix_data_t tbl_data [`MSIX_NUM_VECTORS];
   logic [`MSIX_NUM_VECTORS-1:0] tbl_mask;

   msix_vec_if vec_if [`MSIX_NUM_VECTORS] ();
   msix_msg_if msg_if ();

   msix_table u_table (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_cfg_wr    (i_cfg_wr),
      .i_cfg_vec   (i_cfg_vec),
      .i_cfg_word  (i_cfg_word),
      .i_cfg_wdata (i_cfg_wdata),
      .o_addr      (tbl_addr),
      .o_data      (tbl_data),
      .o_mask      (tbl_mask)
   );

   // --------------------------------------------------
   // One pending tracker per vector
   // --------------------------------------------------
   generate
      for (genvar g = 0; g < `MSIX_NUM_VECTORS; g++) begin : g_vec
         msix_vector u_vector (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_irq     (i_irq[g]),
            .i_mask    (tbl_mask[g]),
            .i_addr    (tbl_addr[g]),
            .i_data    (tbl_data[g]),
            .o_pending (o_pba[g]),
            .port_vec  (vec_if[g])
         );
      end
   endgenerate

   msix_arbiter u_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .port_vecs (vec_if),
      .port_msg  (msg_if)
   );

   msix_bridge u_bridge (
      .clk          (clk),
      .rst_n        (rst_n),
      .port_msg     (msg_if),
      .i_msix_ready (i_msix_ready),
      .o_msix_valid (o_msix_valid),
      .o_msix_addr  (o_msix_addr),
      .o_msix_data  (o_msix_data)
   );

endmodule

// File: verification/msix_tb.sv
`timescale 1ns/1ps
`include "msix_defs.svh"

module msix_tb;
   import msix_pkg::*;

   // About ten times the cycles that all tests take together
   localparam int TIMEOUT_CYCLES = 5000;
   localparam int WAIT_LIMIT = 200;

   logic clk;
   logic rst_n;
   logic i_cfg_wr;
   msix_vec_t i_cfg_vec;
   logic [1:0] i_cfg_word;
   cfg_word_t i_cfg_wdata;
   logic [`MSIX_NUM_VECTORS-1:0] i_irq;
   logic i_msix_ready;
   logic o_msix_valid;
   msix_addr_t o_msix_addr;
   msix_data_t o_msix_data;
   logic [`MSIX_NUM_VECTORS-1:0] o_pba;

   // Table contents as written by the testbench
   msix_addr_t exp_addr [`MSIX_NUM_VECTORS];
   msix_data_t exp_data [`MSIX_NUM_VECTORS];
   logic [95:0] got_q [$];
   integer seed = 32'hafcd;
   int cycle_cnt = 0;

   msix_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_cfg_wr     (i_cfg_wr),
      .i_cfg_vec    (i_cfg_vec),
      .i_cfg_word   (i_cfg_word),
      .i_cfg_wdata  (i_cfg_wdata),
      .i_irq        (i_irq),
      .i_msix_ready (i_msix_ready),
      .o_msix_valid (o_msix_valid),
      .o_msix_addr  (o_msix_addr),
      .o_msix_data  (o_msix_data),
      .o_pba        (o_pba)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // --------------------------------------------------
   // Monitor and timeout
   // --------------------------------------------------
   // Mid-cycle sample of each accepted message
   always @(negedge clk) begin
      if (rst_n && o_msix_valid && i_msix_ready) begin
         got_q.push_back({o_msix_addr, o_msix_data});
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_error($sformatf("Timeout, run exceeded %0d cycles", TIMEOUT_CYCLES));
      end
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic cfg_write(input int v, input logic [1:0] word, input cfg_word_t wdata);
      i_cfg_wr    = 1'b1;
      i_cfg_vec   = msix_vec_t'(v);
      i_cfg_word  = word;
      i_cfg_wdata = wdata;
      next_cycle();
      i_cfg_wr = 1'b0;
   endtask

   task automatic set_mask(input int v, input logic m);
      cfg_write(v, `MSIX_WORD_CTRL, {31'b0, m});
   endtask

   task automatic program_vector(input int v, input logic m);
      exp_addr[v] = {$random(seed), $random(seed)};
      exp_data[v] = $random(seed);
      cfg_write(v, `MSIX_WORD_ADDR_LO, exp_addr[v][31:0]);
      cfg_write(v, `MSIX_WORD_ADDR_HI, exp_addr[v][63:32]);
      cfg_write(v, `MSIX_WORD_DATA, exp_data[v]);
      set_mask(v, m);
   endtask

   task automatic pulse_irq(input logic [`MSIX_NUM_VECTORS-1:0] bits);
      i_irq = bits;
      next_cycle();
      i_irq = '0;
   endtask

   task automatic settle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic wait_for_messages(input int n);
      int cnt;
      cnt = 0;
      while (got_q.size() < n && cnt < WAIT_LIMIT) begin
         next_cycle();
         cnt++;
      end
      assert (got_q.size() >= n) else
         stop_with_error($sformatf("Waited for %0d messages, only %0d arrived",
                                   n, got_q.size()));
   endtask

   // Pops one message and compares it with the entry of vector v
   task automatic check_message(input int v);
      logic [95:0] msg;
      msg = got_q.pop_front();
      assert (msg[95:32] == exp_addr[v]) else
         stop_with_error($sformatf("Error: o_msix_addr got %h expected %h",
                                   msg[95:32], exp_addr[v]));
      assert (msg[31:0] == exp_data[v]) else
         stop_with_error($sformatf("Error: o_msix_data got %h expected %h",
                                   msg[31:0], exp_data[v]));
   endtask

   task automatic expect_quiet(input int n);
      repeat (n) begin
         next_cycle();
         assert (!o_msix_valid && got_q.size() == 0) else
            stop_with_error("A message appeared while none was expected");
      end
   endtask

   function automatic int find_entry(input logic [95:0] msg);
      for (int v = 0; v < `MSIX_NUM_VECTORS; v++) begin
         if (msg == {exp_addr[v], exp_data[v]}) return v;
      end
      return -1;
   endfunction

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic after_reset();
      assert (o_msix_valid == 1'b0) else
         stop_with_error($sformatf("Error: o_msix_valid got %h expected 0", o_msix_valid));
      assert (o_pba == '0) else
         stop_with_error($sformatf("Error: o_pba got %h expected 0", o_pba));
   endtask

   task automatic one_per_vector();
      i_msix_ready = 1'b1;
      for (int v = 0; v < `MSIX_NUM_VECTORS; v++) begin
         program_vector(v, 1'b0);
      end
      for (int v = 0; v < `MSIX_NUM_VECTORS; v++) begin
         pulse_irq(`MSIX_NUM_VECTORS'(1) << v);
         wait_for_messages(1);
         settle(20);
         assert (got_q.size() == 1) else
            stop_with_error($sformatf("Vector %0d gave %0d messages instead of one",
                                      v, got_q.size()));
         check_message(v);
      end
   endtask

   task automatic masked_hold();
      set_mask(2, 1'b1);
      pulse_irq(4'b0100);
      assert (o_pba == 4'b0100) else
         stop_with_error($sformatf("Error: o_pba got %h expected 4", o_pba));
      expect_quiet(50);
      set_mask(2, 1'b0);
      wait_for_messages(1);
      settle(20);
      assert (got_q.size() == 1) else
         stop_with_error("Unmasking did not give exactly one message");
      check_message(2);
      assert (o_pba == '0) else
         stop_with_error($sformatf("Error: o_pba got %h expected 0", o_pba));
   endtask

   task automatic coalesce_repeats();
      set_mask(1, 1'b1);
      repeat (3) begin
         pulse_irq(4'b0010);
         next_cycle();
      end
      expect_quiet(10);
      set_mask(1, 1'b0);
      wait_for_messages(1);
      settle(30);
      assert (got_q.size() == 1) else
         stop_with_error("Repeated pulses on a masked vector did not merge into one");
      check_message(1);
   endtask

   task automatic backpressure_hold();
      msix_addr_t held_addr;
      msix_data_t held_data;
      logic [`MSIX_NUM_VECTORS-1:0] seen;
      int cnt;
      int idx;
      i_msix_ready = 1'b0;
      pulse_irq('1);
      cnt = 0;
      while (!o_msix_valid && cnt < WAIT_LIMIT) begin
         next_cycle();
         cnt++;
      end
      assert (o_msix_valid) else
         stop_with_error("o_msix_valid never rose with ready held low");
      held_addr = o_msix_addr;
      held_data = o_msix_data;
      repeat (30) begin
         next_cycle();
         assert (o_msix_valid) else
            stop_with_error("o_msix_valid dropped while ready was held low");
         assert (o_msix_addr == held_addr) else
            stop_with_error($sformatf("Error: o_msix_addr got %h expected %h",
                                      o_msix_addr, held_addr));
         assert (o_msix_data == held_data) else
            stop_with_error($sformatf("Error: o_msix_data got %h expected %h",
                                      o_msix_data, held_data));
      end
      i_msix_ready = 1'b1;
      wait_for_messages(4);
      settle(30);
      assert (got_q.size() == 4) else
         stop_with_error("Back-pressure run did not give exactly four messages");
      // Arrival order depends on the arbiter, so compare as a set
      seen = '0;
      while (got_q.size() > 0) begin
         idx = find_entry(got_q.pop_front());
         assert (idx >= 0 && !seen[idx]) else
            stop_with_error("A message matched no entry or repeated one");
         seen[idx] = 1'b1;
      end
      assert (o_pba == '0) else
         stop_with_error($sformatf("Error: o_pba got %h expected 0", o_pba));
   endtask

   initial begin
      rst_n        = 1'b0;
      i_cfg_wr     = 1'b0;
      i_cfg_vec    = '0;
      i_cfg_word   = '0;
      i_cfg_wdata  = '0;
      i_irq        = '0;
      i_msix_ready = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();
      after_reset();
      one_per_vector();
      masked_hold();
      coalesce_repeats();
      backpressure_hold();
      settle(20);
      if (got_q.size() == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("%0d messages arrived after the last test", got_q.size());
         $display("TB FAILED");
         $fatal(1);
      end
   end

endmodule

// File: list.f
+incdir+verilog
verilog/msix_pkg.sv
verilog/msix_vec_if.sv
verilog/msix_msg_if.sv
verilog/msix_table.sv
verilog/msix_vector.sv
verilog/msix_arbiter.sv
verilog/msix_fifo.sv
verilog/msix_bridge.sv
verilog/msix_top.sv
verification/msix_tb.sv
